//--- design/bubsys_video_pkg.sv
package bubsys_video_pkg;

    ////////////////////
    // Bus and memory widths
    ////////////////////

    typedef logic [8:0]  hcount_t;       // Pixel counter, 128..511
    typedef logic [8:0]  vcount_t;       // Line counter, 248..511
    typedef logic [14:0] cpu_addr_t;     // 68k word address
    typedef logic [15:0] cpu_data_t;
    typedef logic [7:0]  byte_t;         // One RAM lane
    typedef logic [10:0] scroll_addr_t;  // 2k scroll RAM
    typedef logic [11:0] vram_addr_t;    // 4k tile VRAM

    // Tile attribute fields
    typedef logic [10:0] tile_code_t;    // VRAM1 bits 10:0
    typedef logic [6:0]  tile_color_t;   // VRAM2 bits 6:0
    typedef logic [3:0]  tile_prio_t;    // VRAM1 bits 15:12

    ////////////////////
    // Raster geometry
    ////////////////////

    // 384 pixels per line
    localparam hcount_t H_FIRST     = 9'd128;
    localparam hcount_t H_LAST      = 9'd511;
    localparam hcount_t HBLANK_LAST = 9'd255;  // Blank from H_FIRST up to here

    // 264 lines per frame
    localparam vcount_t V_FIRST     = 9'd248;
    localparam vcount_t V_LAST      = 9'd511;

    // Sync spans, inclusive
    localparam hcount_t HSYNC_FIRST = 9'd144;
    localparam hcount_t HSYNC_LAST  = 9'd175;
    localparam vcount_t VSYNC_FIRST = 9'd248;
    localparam vcount_t VSYNC_LAST  = 9'd255;

    // Undriven bus reads back as pull-ups
    localparam cpu_data_t BUS_IDLE  = 16'hFFFF;

endpackage

//--- design/cen_divider.sv
module cen_divider
(
    input  logic i_EMU_MCLK,
    input  logic i_rst_n,
    input  logic i_EMU_CLK18MNCEN_n,     // 18 MHz enable, active low

    output logic o_EMU_CLK9MPCEN_n,
    output logic o_EMU_CLK9MNCEN_n,
    output logic o_EMU_CLK6MPCEN_n,
    output logic o_EMU_CLK6MNCEN_n
);

    ////////////////////
    // Six-step sequencer
    ////////////////////

    logic [2:0] step;                    // 0..5, one step per 18 MHz enable
    logic [3:0] cen_pat;                 // {9P, 9N, 6P, 6N}, low = fire

    always_ff @(posedge i_EMU_MCLK)
    begin
        if (!i_rst_n)
        begin
            step    <= 3'd5;             // First enable after reset lands on step 0
            cen_pat <= 4'b1111;          // All idle
        end
        else if (!i_EMU_CLK18MNCEN_n)
        begin
            if (step == 3'd5)
            begin
                step <= 3'd0;
            end
            else
            begin
                step <= step + 3'd1;
            end

            // 9 MHz alternates P/N, 6 MHz fires once per three steps
            case (step)
                3'd0:    cen_pat <= 4'b0110;
                3'd1:    cen_pat <= 4'b1001;
                3'd2:    cen_pat <= 4'b0111;
                3'd3:    cen_pat <= 4'b1010;
                3'd4:    cen_pat <= 4'b0101;
                3'd5:    cen_pat <= 4'b1011;
                default: cen_pat <= 4'b1111; // Unreachable step
            endcase
        end
    end

    // Pattern only counts in a cycle where 18 MHz fires
    assign o_EMU_CLK9MPCEN_n = cen_pat[3] | i_EMU_CLK18MNCEN_n;
    assign o_EMU_CLK9MNCEN_n = cen_pat[2] | i_EMU_CLK18MNCEN_n;
    assign o_EMU_CLK6MPCEN_n = cen_pat[1] | i_EMU_CLK18MNCEN_n;  // Pixel clock
    assign o_EMU_CLK6MNCEN_n = cen_pat[0] | i_EMU_CLK18MNCEN_n;

endmodule

//--- design/raster_timing.sv
module raster_timing
    import bubsys_video_pkg::*;
#(
    parameter int V_ACTIVE_FIRST = 272,  // First visible line
    parameter int V_ACTIVE_LAST  = 495   // Last visible line
)
(
    input  logic    i_EMU_MCLK,
    input  logic    i_rst_n,
    input  logic    i_cen6p_n,           // Pixel enable

    output hcount_t o_hcount,
    output vcount_t o_vcount,

    output logic    o_cpu_slot,          // Scroll RAM belongs to CPU
    output logic    o_vram_slot,         // VRAM belongs to CPU
    output logic    o_fetch_strobe,      // Tile attribute capture point

    output logic    o_VBLANK_n,
    output logic    o_VSYNC_n,
    output logic    o_SYNC_n             // Registered composite sync
);

    ////////////////////
    // Counters
    ////////////////////

    always_ff @(posedge i_EMU_MCLK)
    begin
        if (!i_rst_n)
        begin
            o_hcount <= H_FIRST;
            o_vcount <= V_FIRST;
        end
        else if (!i_cen6p_n)
        begin
            if (o_hcount == H_LAST)
            begin
                o_hcount <= H_FIRST;     // Line wrap, 384 pixels
                if (o_vcount == V_LAST)
                begin
                    o_vcount <= V_FIRST; // Frame wrap, 264 lines
                end
                else
                begin
                    o_vcount <= o_vcount + vcount_t'(1);
                end
            end
            else
            begin
                o_hcount <= o_hcount + hcount_t'(1);
            end
        end
    end

    ////////////////////
    // Blanking and sync
    ////////////////////

    logic hblank;                        // Left part of the line, H_FIRST..HBLANK_LAST
    logic hsync_n;

    assign hblank = (o_hcount <= HBLANK_LAST);

    // Sync pulse sits inside horizontal blank
    assign hsync_n = ~(hblank &&
                       (o_hcount >= HSYNC_FIRST) &&
                       (o_hcount <= HSYNC_LAST));

    assign o_VSYNC_n = ~((o_vcount >= VSYNC_FIRST) && (o_vcount <= VSYNC_LAST));

    // Visible lines only
    assign o_VBLANK_n = (o_vcount >= vcount_t'(V_ACTIVE_FIRST)) &&
                        (o_vcount <= vcount_t'(V_ACTIVE_LAST));

    // Composite sync sampled on pixel 3 of each 8-pixel group
    always_ff @(posedge i_EMU_MCLK)
    begin
        if (!i_rst_n)
        begin
            o_SYNC_n <= 1'b1;
        end
        else if (!i_cen6p_n && (o_hcount[2:0] == 3'd3))
        begin
            o_SYNC_n <= hsync_n & o_VSYNC_n;  // Either sync low pulls it low
        end
    end

    ////////////////////
    // Memory slots
    ////////////////////

    assign o_cpu_slot     = ~o_hcount[0];            // Even pixels
    assign o_vram_slot    = (o_hcount[1:0] == 2'd0); // Pixels 0 and 4
    assign o_fetch_strobe = (o_hcount[1:0] == 2'd3); // Pixels 3 and 7

endmodule

//--- design/scroll_ram_port.sv
module scroll_ram_port
    import bubsys_video_pkg::*;
(
    input  logic         i_EMU_MCLK,
    input  logic         i_rst_n,
    input  logic         i_cen6p_n,
    input  logic         i_cpu_slot,
    input  vcount_t      i_vcount,

    input  scroll_addr_t i_cpu_addr,
    input  logic         i_wr,           // Already slot gated
    input  byte_t        i_din,

    output byte_t        o_rd_latch      // CPU side read latch
);

    byte_t        scroll_mem [2048];
    byte_t        ram_q;
    scroll_addr_t ram_addr;
    scroll_addr_t gfx_addr;

    // Graphics side walks one entry per line
    assign gfx_addr = {2'b00, i_vcount};
    assign ram_addr = i_cpu_slot ? i_cpu_addr : gfx_addr;

    always_ff @(posedge i_EMU_MCLK)
    begin
        if (i_wr)
        begin
            scroll_mem[ram_addr] <= i_din;
        end
        ram_q <= scroll_mem[ram_addr];   // Address held for the whole pixel
    end

    // Reload on every CPU slot, data is from the CPU address
    always_ff @(posedge i_EMU_MCLK)
    begin
        if (!i_rst_n)
        begin
            o_rd_latch <= '0;
        end
        else if (!i_cen6p_n && i_cpu_slot)
        begin
            o_rd_latch <= ram_q;
        end
    end

endmodule

//--- design/vram_port.sv
module vram_port
    import bubsys_video_pkg::*;
(
    input  logic        i_EMU_MCLK,
    input  logic        i_rst_n,
    input  logic        i_cen6p_n,
    input  logic        i_vram_slot,
    input  logic        i_fetch_strobe,
    input  hcount_t     i_hcount,
    input  vcount_t     i_vcount,

    input  vram_addr_t  i_cpu_addr,
    input  logic        i_wr1h,          // VRAM1 upper lane
    input  logic        i_wr1l,          // VRAM1 lower lane
    input  logic        i_wr2l,          // VRAM2
    input  cpu_data_t   i_din,

    output cpu_data_t   o_vram1_dout,
    output byte_t       o_vram2_dout,

    output tile_code_t  o_tile_code,
    output logic        o_tile_vflip,
    output tile_color_t o_tile_color,
    output tile_prio_t  o_tile_prio
);

    cpu_data_t  vram1 [4096];            // Code, vflip, priority
    byte_t      vram2 [4096];            // Colour
    cpu_data_t  vram1_q;
    byte_t      vram2_q;
    vram_addr_t ram_addr;
    vram_addr_t gfx_addr;

    // Layer from 4H, 32 rows by 64 columns of 8x8 tiles
    assign gfx_addr = {i_hcount[2], i_vcount[7:3], i_hcount[8:3]};
    assign ram_addr = i_vram_slot ? i_cpu_addr : gfx_addr;

    always_ff @(posedge i_EMU_MCLK)
    begin
        if (i_wr1h)
        begin
            vram1[ram_addr][15:8] <= i_din[15:8];
        end
        if (i_wr1l)
        begin
            vram1[ram_addr][7:0] <= i_din[7:0];
        end
        if (i_wr2l)
        begin
            vram2[ram_addr] <= i_din[7:0];
        end
        vram1_q <= vram1[ram_addr];
        vram2_q <= vram2[ram_addr];
    end

    ////////////////////
    // Output latches
    ////////////////////

    always_ff @(posedge i_EMU_MCLK)
    begin
        if (!i_rst_n)
        begin
            o_vram1_dout <= '0;
            o_vram2_dout <= '0;
            o_tile_code  <= '0;
            o_tile_vflip <= 1'b0;
            o_tile_color <= '0;
            o_tile_prio  <= '0;
        end
        else if (!i_cen6p_n)
        begin
            if (i_vram_slot)             // CPU read window
            begin
                o_vram1_dout <= vram1_q;
                o_vram2_dout <= vram2_q;
            end
            if (i_fetch_strobe)          // Graphics address settled
            begin
                o_tile_code  <= vram1_q[10:0];
                o_tile_vflip <= vram1_q[11];
                o_tile_prio  <= vram1_q[15:12];
                o_tile_color <= vram2_q[6:0];
            end
        end
    end

endmodule

//--- design/cpu_bus_decode.sv
module cpu_bus_decode
    import bubsys_video_pkg::*;
(
    input  logic      i_cen6p_n,
    input  logic      i_cpu_slot,
    input  logic      i_vram_slot,

    input  logic      i_VZCS_n,          // Scroll RAM select
    input  logic      i_VCS1_n,          // VRAM1 select
    input  logic      i_VCS2_n,          // VRAM2 select
    input  logic      i_CPU_RW,          // High = read
    input  logic      i_CPU_UDS_n,
    input  logic      i_CPU_LDS_n,

    input  byte_t     i_scroll_q,
    input  cpu_data_t i_vram1_q,
    input  byte_t     i_vram2_q,

    output logic      o_scroll_wr,
    output logic      o_vram1h_wr,
    output logic      o_vram1l_wr,
    output logic      o_vram2l_wr,
    output cpu_data_t o_CPU_DOUT
);

    ////////////////////
    // Write strobes
    ////////////////////

    logic cpu_wr;                        // Write cycle on this pixel enable
    logic scroll_go;
    logic vram_go;

    assign cpu_wr    = ~i_CPU_RW & ~i_cen6p_n;
    assign scroll_go = cpu_wr & i_cpu_slot;
    assign vram_go   = cpu_wr & i_vram_slot;

    // Scroll RAM and VRAM2 only have the lower lane
    assign o_scroll_wr = scroll_go & ~i_VZCS_n & ~i_CPU_LDS_n;
    assign o_vram1h_wr = vram_go   & ~i_VCS1_n & ~i_CPU_UDS_n;
    assign o_vram1l_wr = vram_go   & ~i_VCS1_n & ~i_CPU_LDS_n;
    assign o_vram2l_wr = vram_go   & ~i_VCS2_n & ~i_CPU_LDS_n;

    ////////////////////
    // Read data mux
    ////////////////////

    always_comb
    begin
        case ({i_VZCS_n, i_VCS1_n, i_VCS2_n})
            3'b011:  o_CPU_DOUT = {BUS_IDLE[15:8], i_scroll_q};  // Upper byte floats high
            3'b101:  o_CPU_DOUT = i_vram1_q;
            3'b110:  o_CPU_DOUT = {BUS_IDLE[15:8], i_vram2_q};
            default: o_CPU_DOUT = BUS_IDLE;  // None, or a select clash
        endcase
    end

endmodule

//--- design/bubsys_video.sv
module bubsys_video
    import bubsys_video_pkg::*;
#(
    parameter int V_ACTIVE_FIRST = 272,
    parameter int V_ACTIVE_LAST  = 495
)
(
    input  logic        i_EMU_MCLK,
    input  logic        i_rst_n,
    input  logic        i_EMU_CLK18MNCEN_n,

    output logic        o_EMU_CLK9MPCEN_n,
    output logic        o_EMU_CLK9MNCEN_n,
    output logic        o_EMU_CLK6MPCEN_n,
    output logic        o_EMU_CLK6MNCEN_n,

    input  cpu_addr_t   i_CPU_ADDR,
    input  cpu_data_t   i_CPU_DIN,
    output cpu_data_t   o_CPU_DOUT,
    input  logic        i_CPU_RW,
    input  logic        i_CPU_UDS_n,
    input  logic        i_CPU_LDS_n,

    input  logic        i_VZCS_n,
    input  logic        i_VCS1_n,
    input  logic        i_VCS2_n,

    output logic        o_VBLANK_n,
    output logic        o_VSYNC_n,
    output logic        o_SYNC_n,

    output tile_code_t  o_tile_code,
    output logic        o_tile_vflip,
    output tile_color_t o_tile_color,
    output tile_prio_t  o_tile_prio
);

    hcount_t   hcount;
    vcount_t   vcount;
    logic      cpu_slot;
    logic      vram_slot;
    logic      fetch_strobe;
    logic      scroll_wr;
    logic      vram1h_wr;
    logic      vram1l_wr;
    logic      vram2l_wr;
    byte_t     scroll_q;
    cpu_data_t vram1_q;
    byte_t     vram2_q;

    ////////////////////
    // Clocking and raster
    ////////////////////

    cen_divider u_cen_divider
    (
        .i_EMU_MCLK         (i_EMU_MCLK),
        .i_rst_n            (i_rst_n),
        .i_EMU_CLK18MNCEN_n (i_EMU_CLK18MNCEN_n),
        .o_EMU_CLK9MPCEN_n  (o_EMU_CLK9MPCEN_n),
        .o_EMU_CLK9MNCEN_n  (o_EMU_CLK9MNCEN_n),
        .o_EMU_CLK6MPCEN_n  (o_EMU_CLK6MPCEN_n),  // Also the pixel enable below
        .o_EMU_CLK6MNCEN_n  (o_EMU_CLK6MNCEN_n)
    );

    raster_timing #(
        .V_ACTIVE_FIRST (V_ACTIVE_FIRST),
        .V_ACTIVE_LAST  (V_ACTIVE_LAST)
    ) u_raster_timing
    (
        .i_EMU_MCLK     (i_EMU_MCLK),
        .i_rst_n        (i_rst_n),
        .i_cen6p_n      (o_EMU_CLK6MPCEN_n),
        .o_hcount       (hcount),
        .o_vcount       (vcount),
        .o_cpu_slot     (cpu_slot),
        .o_vram_slot    (vram_slot),
        .o_fetch_strobe (fetch_strobe),
        .o_VBLANK_n     (o_VBLANK_n),
        .o_VSYNC_n      (o_VSYNC_n),
        .o_SYNC_n       (o_SYNC_n)
    );

    ////////////////////
    // Memory ports
    ////////////////////

    scroll_ram_port u_scroll_ram_port
    (
        .i_EMU_MCLK (i_EMU_MCLK),
        .i_rst_n    (i_rst_n),
        .i_cen6p_n  (o_EMU_CLK6MPCEN_n),
        .i_cpu_slot (cpu_slot),
        .i_vcount   (vcount),
        .i_cpu_addr (i_CPU_ADDR[10:0]),   // 2k window
        .i_wr       (scroll_wr),
        .i_din      (i_CPU_DIN[7:0]),
        .o_rd_latch (scroll_q)
    );

    vram_port u_vram_port
    (
        .i_EMU_MCLK     (i_EMU_MCLK),
        .i_rst_n        (i_rst_n),
        .i_cen6p_n      (o_EMU_CLK6MPCEN_n),
        .i_vram_slot    (vram_slot),
        .i_fetch_strobe (fetch_strobe),
        .i_hcount       (hcount),
        .i_vcount       (vcount),
        .i_cpu_addr     (i_CPU_ADDR[11:0]),  // 4k window
        .i_wr1h         (vram1h_wr),
        .i_wr1l         (vram1l_wr),
        .i_wr2l         (vram2l_wr),
        .i_din          (i_CPU_DIN),
        .o_vram1_dout   (vram1_q),
        .o_vram2_dout   (vram2_q),
        .o_tile_code    (o_tile_code),
        .o_tile_vflip   (o_tile_vflip),
        .o_tile_color   (o_tile_color),
        .o_tile_prio    (o_tile_prio)
    );

    cpu_bus_decode u_cpu_bus_decode
    (
        .i_cen6p_n   (o_EMU_CLK6MPCEN_n),
        .i_cpu_slot  (cpu_slot),
        .i_vram_slot (vram_slot),
        .i_VZCS_n    (i_VZCS_n),
        .i_VCS1_n    (i_VCS1_n),
        .i_VCS2_n    (i_VCS2_n),
        .i_CPU_RW    (i_CPU_RW),
        .i_CPU_UDS_n (i_CPU_UDS_n),
        .i_CPU_LDS_n (i_CPU_LDS_n),
        .i_scroll_q  (scroll_q),
        .i_vram1_q   (vram1_q),
        .i_vram2_q   (vram2_q),
        .o_scroll_wr (scroll_wr),
        .o_vram1h_wr (vram1h_wr),
        .o_vram1l_wr (vram1l_wr),
        .o_vram2l_wr (vram2l_wr),
        .o_CPU_DOUT  (o_CPU_DOUT)
    );

endmodule

//--- sim/bubsys_video_chk.sv
module bubsys_video_chk
    import bubsys_video_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_cen6p_n,
    input  logic      i_cen6n_n,
    input  hcount_t   i_hcount,
    input  cpu_data_t i_dout,
    input  logic      i_vzcs_n,
    input  logic      i_vcs1_n,
    input  logic      i_vcs2_n
);

    ////////////////////
    // Enable phases
    ////////////////////

    // Pixel enable pair is never low in one cycle
    a_cen6_exclusive: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(!i_cen6p_n && !i_cen6n_n))
        else $error("6 MHz positive and negative enables low together");

    ////////////////////
    // Raster range
    ////////////////////

    a_hcount_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_hcount >= H_FIRST) && (i_hcount <= H_LAST))
        else $error("H counter outside its range");

    // Nothing selected, pull-ups win
    a_idle_bus: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_vzcs_n && i_vcs1_n && i_vcs2_n) |-> (i_dout == BUS_IDLE))
        else $error("Read bus not idle with no select");

endmodule

bind bubsys_video bubsys_video_chk u_chk
(
    .i_clk     (i_EMU_MCLK),
    .i_rst_n   (i_rst_n),
    .i_cen6p_n (o_EMU_CLK6MPCEN_n),
    .i_cen6n_n (o_EMU_CLK6MNCEN_n),
    .i_hcount  (hcount),          // Raster counter inside the top level
    .i_dout    (o_CPU_DOUT),
    .i_vzcs_n  (i_VZCS_n),
    .i_vcs1_n  (i_VCS1_n),
    .i_vcs2_n  (i_VCS2_n)
);

//--- sim/bubsys_video_tb.sv
module bubsys_video_tb
    import bubsys_video_pkg::*;
();

    localparam int SEL_SCROLL = 0;
    localparam int SEL_V1     = 1;
    localparam int SEL_V2     = 2;
    localparam int SEL_NONE   = 3;

    logic        clk;
    logic        rst_n;
    logic        cen18_n;
    cpu_addr_t   addr;
    cpu_data_t   din;
    cpu_data_t   dout;
    logic        rw;
    logic        uds_n;
    logic        lds_n;
    logic        vzcs_n;
    logic        vcs1_n;
    logic        vcs2_n;
    logic        cen9p_n;
    logic        cen9n_n;
    logic        cen6p_n;
    logic        cen6n_n;
    logic        vblank_n;
    logic        vsync_n;
    logic        sync_n;
    tile_code_t  tile_code;
    logic        tile_vflip;
    tile_color_t tile_color;
    tile_prio_t  tile_prio;

    int          value_errors = 0;
    int          timeouts     = 0;
    longint      pix_total    = 0;   // Pixel enables seen by wait_level
    logic [31:0] lfsr         = 32'hc43c;

    bubsys_video #(.V_ACTIVE_FIRST(272), .V_ACTIVE_LAST(495)) i_dut
    (
        .i_EMU_MCLK (clk), .i_rst_n (rst_n), .i_EMU_CLK18MNCEN_n (cen18_n),
        .o_EMU_CLK9MPCEN_n (cen9p_n), .o_EMU_CLK9MNCEN_n (cen9n_n),
        .o_EMU_CLK6MPCEN_n (cen6p_n), .o_EMU_CLK6MNCEN_n (cen6n_n),
        .i_CPU_ADDR (addr), .i_CPU_DIN (din), .o_CPU_DOUT (dout),
        .i_CPU_RW (rw), .i_CPU_UDS_n (uds_n), .i_CPU_LDS_n (lds_n),
        .i_VZCS_n (vzcs_n), .i_VCS1_n (vcs1_n), .i_VCS2_n (vcs2_n),
        .o_VBLANK_n (vblank_n), .o_VSYNC_n (vsync_n), .o_SYNC_n (sync_n),
        .o_tile_code (tile_code), .o_tile_vflip (tile_vflip),
        .o_tile_color (tile_color), .o_tile_prio (tile_prio)
    );

    // MCLK, with the 18 MHz enable low on every second cycle
    initial
    begin
        clk     = 1'b0;
        cen18_n = 1'b1;
        forever
        begin
            #4 clk = 1'b1;
            #1 cen18_n = ~cen18_n;
            #3 clk = 1'b0;
        end
    end

    ////////////////////
    // Helpers
    ////////////////////

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return r;
    endfunction

    task automatic timeout(input string what);
        timeouts++;
        $display("Timeout while waiting for %s at time %0t", what, $time);
    endtask

    task automatic check_data(input cpu_data_t got, input cpu_data_t exp, input string what);
        if (got !== exp)
        begin
            value_errors++;
            $display("Fail @%0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_byte(input byte_t got, input byte_t exp, input string what);
        if (got !== exp)
        begin
            value_errors++;
            $display("Fail @%0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_code(input tile_code_t got, input tile_code_t exp, input string what);
        if (got !== exp)
        begin
            value_errors++;
            $display("Fail @%0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            value_errors++;
            $display("Fail @%0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input longint got, input longint exp, input string what);
        if (got != exp)
        begin
            value_errors++;
            $display("Fail @%0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic set_select(input int sel);
        vzcs_n = (sel != SEL_SCROLL);
        vcs1_n = (sel != SEL_V1);
        vcs2_n = (sel != SEL_V2);
    endtask

    // Counts pixel enables at falling edges, where outputs are settled
    task automatic wait_pix(input int n);
        int seen;
        int guard;
        seen  = 0;
        guard = 0;
        while (seen < n && guard < n * 8 + 16)
        begin
            @(negedge clk);
            guard++;
            if (!cen6p_n)
                seen++;
        end
        if (seen < n)
            timeout("pixel enables");
    endtask

    // which 0 = VBLANK_n, 1 = VSYNC_n, 2 = SYNC_n
    function automatic logic video_level(input int which);
        case (which)
            0:       return vblank_n;
            1:       return vsync_n;
            default: return sync_n;
        endcase
    endfunction

    task automatic wait_level(input int which, input logic level);
        int   guard;
        logic done;
        guard = 0;
        done  = 1'b0;
        while (!done && guard < 700000)
        begin
            @(negedge clk);
            guard++;
            if (video_level(which) === level)
                done = 1'b1;
            else if (!cen6p_n)
                pix_total++;     // Enable ahead of the change still counts
        end
        if (!done)
            timeout($sformatf("level %b on video output %0d", level, which));
    endtask

    task automatic cpu_write(input int sel, input int a, input cpu_data_t d,
                             input logic u_n, input logic l_n);
        @(posedge clk);
        #1;
        addr  = cpu_addr_t'(a);
        din   = d;
        rw    = 1'b0;
        uds_n = u_n;
        lds_n = l_n;
        set_select(sel);
        wait_pix(8);               // Held across several slots
        @(posedge clk);
        #1;
        rw    = 1'b1;
        uds_n = 1'b1;
        lds_n = 1'b1;
        set_select(SEL_NONE);
    endtask

    task automatic cpu_read(input int sel, input int a, output cpu_data_t d);
        @(posedge clk);
        #1;
        addr  = cpu_addr_t'(a);
        rw    = 1'b1;
        uds_n = 1'b0;
        lds_n = 1'b0;
        set_select(sel);
        wait_pix(8);
        d = dout;                  // Still at the falling edge
        @(posedge clk);
        #1;
        uds_n = 1'b1;
        lds_n = 1'b1;
        set_select(SEL_NONE);
    endtask

    ////////////////////
    // Directed tests
    ////////////////////

    task automatic test_enable_ratio();
        int en;
        int guard;
        int c9p;
        int c9n;
        int c6p;
        int c6n;
        en    = 0;
        guard = 0;
        c9p   = 0;
        c9n   = 0;
        c6p   = 0;
        c6n   = 0;
        while (en < 67 && guard < 400)
        begin
            @(negedge clk);
            guard++;
            if (!cen18_n)
            begin
                en++;
                if (en > 7)        // Skip the settling enables
                begin
                    c9p += (cen9p_n == 1'b0) ? 1 : 0;
                    c9n += (cen9n_n == 1'b0) ? 1 : 0;
                    c6p += (cen6p_n == 1'b0) ? 1 : 0;
                    c6n += (cen6n_n == 1'b0) ? 1 : 0;
                end
            end
        end
        if (en < 67)
            timeout("18 MHz enables");
        check_count(longint'(c9p), 30, "9 MHz positive pulses");
        check_count(longint'(c9n), 30, "9 MHz negative pulses");
        check_count(longint'(c6p), 20, "6 MHz positive pulses");
        check_count(longint'(c6n), 20, "6 MHz negative pulses");
    endtask

    task automatic test_frame_geometry();
        longint t0;
        longint t1;
        longint t2;
        longint s0;
        longint s1;
        longint c0;
        longint c1;
        longint p0;
        longint p1;
        longint p2;
        wait_level(0, 1'b1);
        wait_level(0, 1'b0);
        t0 = pix_total;
        wait_level(1, 1'b0);       // Frame wrap
        s0 = pix_total;
        wait_level(2, 1'b0);       // Composite follows on pixel 3
        c0 = pix_total;
        wait_level(1, 1'b1);
        s1 = pix_total;
        wait_level(2, 1'b1);
        c1 = pix_total;
        wait_level(0, 1'b1);
        t1 = pix_total;
        wait_level(0, 1'b0);
        t2 = pix_total;

        // Line sync pulse, clear of vertical sync
        wait_level(2, 1'b1);
        wait_level(2, 1'b0);
        p0 = pix_total;
        wait_level(2, 1'b1);
        p1 = pix_total;
        wait_level(2, 1'b0);
        p2 = pix_total;

        check_count(t2 - t0, longint'(264 * 384), "frame period");
        check_count(t1 - t0, longint'(40 * 384), "vblank length");
        check_count(s1 - s0, longint'(8 * 384), "vsync length");
        check_count(c1 - c0, longint'(8 * 384), "composite sync in vsync");
        check_count(p1 - p0, longint'(32), "composite hsync pulse");
        check_count(p2 - p0, longint'(384), "composite hsync period");
    endtask

    task automatic test_scroll_ram();
        byte_t        model [2048];
        scroll_addr_t a [16];
        byte_t        b;
        cpu_data_t    got;
        for (int i = 0; i < 16; i++)
        begin
            a[i]        = scroll_addr_t'(rand_bits(11));
            b           = byte_t'(rand_bits(8));
            model[a[i]] = b;       // Repeated address keeps the last byte
            cpu_write(SEL_SCROLL, int'(a[i]), {8'h00, b}, 1'b1, 1'b0);
        end
        for (int i = 0; i < 16; i++)
        begin
            cpu_read(SEL_SCROLL, int'(a[i]), got);
            check_data(got, {8'hFF, model[a[i]]}, "scroll RAM readback");
        end
    endtask

    task automatic test_vram_lanes();
        vram_addr_t a;
        cpu_data_t  hi;
        cpu_data_t  lo;
        byte_t      b;
        cpu_data_t  got;
        for (int i = 0; i < 8; i++)
        begin
            a  = vram_addr_t'(rand_bits(12));
            hi = cpu_data_t'(rand_bits(16));
            lo = cpu_data_t'(rand_bits(16));
            b  = byte_t'(rand_bits(8));
            cpu_write(SEL_V1, int'(a), hi, 1'b0, 1'b1);  // Upper lane only
            cpu_write(SEL_V1, int'(a), lo, 1'b1, 1'b0);
            cpu_write(SEL_V2, int'(a), {8'h00, b}, 1'b1, 1'b0);
            cpu_read(SEL_V1, int'(a), got);
            check_data(got, {hi[15:8], lo[7:0]}, "VRAM1 merged word");
            cpu_read(SEL_V2, int'(a), got);
            check_data(got, {8'hFF, b}, "VRAM2 byte");
        end
    endtask

    task automatic test_tile_fetch();
        cpu_data_t w;
        byte_t     b;
        w = cpu_data_t'(rand_bits(16));
        b = byte_t'(rand_bits(8));
        for (int a = 0; a < 4096; a++)
        begin
            cpu_write(SEL_V1, a, w, 1'b0, 1'b0);
            cpu_write(SEL_V2, a, {8'h00, b}, 1'b1, 1'b0);
        end
        wait_pix(2 * 384);         // A full line of fetches
        check_code(tile_code, tile_code_t'(w[10:0]), "tile code");
        check_bit(tile_vflip, w[11], "tile vflip");
        check_byte({4'h0, tile_prio}, {4'h0, w[15:12]}, "tile priority");
        check_byte({1'b0, tile_color}, {1'b0, b[6:0]}, "tile colour");
    endtask

    task automatic test_idle_bus();
        @(posedge clk);
        #1;
        set_select(SEL_NONE);
        wait_pix(4);
        check_data(dout, BUS_IDLE, "idle read bus");
    endtask

    ////////////////////
    // Sequence
    ////////////////////

    initial
    begin
        rst_n = 1'b0;
        addr  = '0;
        din   = '0;
        rw    = 1'b1;
        uds_n = 1'b1;
        lds_n = 1'b1;
        set_select(SEL_NONE);

        // Enables stay high all through reset
        repeat (2) @(negedge clk);
        repeat (12)
        begin
            @(negedge clk);
            check_bit(cen9p_n, 1'b1, "9P enable in reset");
            check_bit(cen9n_n, 1'b1, "9N enable in reset");
            check_bit(cen6p_n, 1'b1, "6P enable in reset");
            check_bit(cen6n_n, 1'b1, "6N enable in reset");
        end
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;

        test_idle_bus();
        test_enable_ratio();
        test_frame_geometry();
        test_scroll_ram();
        test_vram_lanes();
        test_tile_fetch();
        test_idle_bus();

        $display("Done with %0d value errors and %0d timeouts", value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

//--- bubsys_video.f
design/bubsys_video_pkg.sv
design/cen_divider.sv
design/raster_timing.sv
design/scroll_ram_port.sv
design/vram_port.sv
design/cpu_bus_decode.sv
design/bubsys_video.sv
sim/bubsys_video_chk.sv
sim/bubsys_video_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the bubsys_video testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module bubsys_video_tb \
    -f bubsys_video.f \
    -o Vbubsys_video_tb

./obj_dir/Vbubsys_video_tb | tee sim.log

if grep -q "Regression passed" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
